// File: panel_pkg.sv
package panel_pkg;

  ////////////////////
  // Frame geometry
  ////////////////////
  localparam int DRIVER_LANES    = 4;
  localparam int CHANNELS        = 4;
  localparam int GRAY_BITS       = 16;
  localparam int LANE_BITS       = CHANNELS * GRAY_BITS;
  localparam int FRAME_BITS      = DRIVER_LANES * LANE_BITS;
  localparam int BLANKING_CYCLES = 128;
  localparam int CONF_BITS       = 24;
  localparam int CONF_LAT_CYCLES = 3;

  // Counter widths
  localparam int BIT_W   = $clog2(GRAY_BITS);
  localparam int CHAN_W  = $clog2(CHANNELS);
  localparam int LANE_W  = $clog2(DRIVER_LANES);
  localparam int BLANK_W = $clog2(BLANKING_CYCLES);
  localparam int FRAME_W = $clog2(FRAME_BITS);
  localparam int CNT_W   = $clog2(LANE_BITS);

  // Status fields
  localparam int SOUT_BITS   = 16;
  localparam int FCOUNT_BITS = 8;

  ////////////////////
  // Register map
  ////////////////////
  localparam int WORD_BITS = 32;
  localparam int ADR_BITS  = 2;

  localparam logic [ADR_BITS-1:0] REG_CTRL     = 2'd0;
  localparam logic [ADR_BITS-1:0] REG_DRV_CONF = 2'd1;
  localparam logic [ADR_BITS-1:0] REG_GRAY     = 2'd2;
  localparam logic [ADR_BITS-1:0] REG_STATUS   = 2'd3;

  typedef logic [1:0] pattern_mode_t;
  typedef logic [5:0] brightness_t;

  // Test patterns
  localparam pattern_mode_t PAT_ZERO  = 2'd0;
  localparam pattern_mode_t PAT_ONES  = 2'd1;
  localparam pattern_mode_t PAT_INDEX = 2'd2;
  localparam pattern_mode_t PAT_FIXED = 2'd3;

  // Controller phases
  localparam int PHASE_BITS = 3;
  localparam logic [PHASE_BITS-1:0] PH_IDLE       = 3'd0;
  localparam logic [PHASE_BITS-1:0] PH_CONF_SHIFT = 3'd1;
  localparam logic [PHASE_BITS-1:0] PH_CONF_LAT   = 3'd2;
  localparam logic [PHASE_BITS-1:0] PH_DATA_SHIFT = 3'd3;
  localparam logic [PHASE_BITS-1:0] PH_DATA_LAT   = 3'd4;
  localparam logic [PHASE_BITS-1:0] PH_GCLK       = 3'd5;

  // One bus word, seen as control or as driver configuration
  typedef union packed {
    struct packed {
      logic [WORD_BITS-10:0] rsvd;
      brightness_t           brightness;
      pattern_mode_t         pattern_mode;
      logic                  run;
    } ctrl;
    struct packed {
      logic [WORD_BITS-CONF_BITS-1:0] rsvd;
      logic [CONF_BITS-1:0]           drv_conf;
    } conf;
  } panel_word_u;

endpackage

// File: panel_wb_regs.sv
module panel_wb_regs (
  input  logic                                 clock_33,
  input  logic                                 nrst,
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [panel_pkg::ADR_BITS-1:0]       wb_adr,
  input  logic [panel_pkg::WORD_BITS-1:0]      wb_dat_w,
  input  logic [panel_pkg::SOUT_BITS-1:0]      sout_capture,
  input  logic [panel_pkg::FCOUNT_BITS-1:0]    frame_count,
  output logic [panel_pkg::WORD_BITS-1:0]      wb_dat_r,
  output logic                                 wb_ack,
  output logic                                 run,
  output panel_pkg::pattern_mode_t             pattern_mode,
  output panel_pkg::brightness_t               brightness,
  output logic [panel_pkg::GRAY_BITS-1:0]      fixed_gray,
  output logic [panel_pkg::CONF_BITS-1:0]      drv_conf,
  output logic                                 conf_load
);
  import panel_pkg::*;

  panel_word_u            wr_word;
  panel_word_u            rd_word;
  logic [WORD_BITS-1:0]   rd_data;
  logic                   access;

  assign wr_word = wb_dat_w;

  // New strobe, no wait states
  assign access = wb_cyc & wb_stb & ~wb_ack;

  ////////////////////
  // Read mux
  ////////////////////
  always_comb begin
    rd_word = '0;
    rd_data = '0;
    case (wb_adr)
      REG_CTRL: begin
        rd_word.ctrl.run          = run;
        rd_word.ctrl.pattern_mode = pattern_mode;
        rd_word.ctrl.brightness   = brightness;
        rd_data                   = rd_word;
      end
      REG_DRV_CONF: begin
        rd_word.conf.drv_conf = drv_conf;
        rd_data               = rd_word;
      end
      REG_GRAY: rd_data = WORD_BITS'(fixed_gray);
      // Frame count above the readback bits
      default: rd_data = WORD_BITS'({frame_count, sout_capture});
    endcase
  end

  ////////////////////
  // Bus cycle and registers
  ////////////////////
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      wb_ack       <= 1'b0;
      wb_dat_r     <= '0;
      run          <= 1'b0;
      pattern_mode <= '0;
      brightness   <= '0;
      fixed_gray   <= '0;
      drv_conf     <= '0;
      conf_load    <= 1'b0;
    end else begin
      wb_ack    <= access;
      conf_load <= access & wb_we & (wb_adr == REG_DRV_CONF);
      if (access) begin
        wb_dat_r <= rd_data;
      end
      if (access && wb_we) begin
        case (wb_adr)
          REG_CTRL: begin
            run          <= wr_word.ctrl.run;
            pattern_mode <= wr_word.ctrl.pattern_mode;
            brightness   <= wr_word.ctrl.brightness;
          end
          REG_DRV_CONF: drv_conf <= wr_word.conf.drv_conf;
          REG_GRAY: fixed_gray <= wb_dat_w[GRAY_BITS-1:0];
          // Status is read only
          default: ;
        endcase
      end
    end
  end

endmodule

// File: framebuffer_emulator.sv
module framebuffer_emulator (
  input  logic                            clock_33,
  input  logic                            nrst,
  input  logic                            run,
  input  panel_pkg::pattern_mode_t        pattern_mode,
  input  logic [panel_pkg::GRAY_BITS-1:0] fixed_gray,
  output logic                            fb_data,
  output logic                            fb_sync
);
  import panel_pkg::*;

  logic                  active;
  pattern_mode_t         mode_q;
  logic [BIT_W-1:0]      bit_cnt;
  logic [CHAN_W-1:0]     chan_cnt;
  logic [LANE_W-1:0]     lane_cnt;
  logic [BLANK_W-1:0]    blank_cnt;
  // Only the low nibble of the frame number is ever shown
  logic [3:0]            frame_num;
  logic [GRAY_BITS-1:0]  gray;
  logic                  first_bit;

  ////////////////////
  // Pattern value
  ////////////////////
  always_comb begin
    case (mode_q)
      PAT_ZERO:  gray = '0;
      PAT_ONES:  gray = '1;
      PAT_INDEX: gray = (GRAY_BITS'(lane_cnt) << 8) | (GRAY_BITS'(chan_cnt) << 4) |
                        GRAY_BITS'(frame_num);
      default:   gray = fixed_gray;
    endcase
  end

  assign first_bit = (lane_cnt == '0) && (chan_cnt == CHAN_W'(CHANNELS - 1)) &&
                     (bit_cnt == BIT_W'(GRAY_BITS - 1));

  ////////////////////
  // Frame walk
  ////////////////////
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      active    <= 1'b0;
      mode_q    <= '0;
      bit_cnt   <= '0;
      chan_cnt  <= '0;
      lane_cnt  <= '0;
      blank_cnt <= '0;
      frame_num <= '0;
      fb_data   <= 1'b0;
      fb_sync   <= 1'b0;
    end else begin
      fb_data <= active & gray[bit_cnt];
      fb_sync <= active & first_bit;
      if (!active) begin
        if (blank_cnt != '0) begin
          blank_cnt <= blank_cnt - 1'b1;
        end else if (run) begin
          // Frame boundary, latch the pattern for the whole frame
          active   <= 1'b1;
          mode_q   <= pattern_mode;
          lane_cnt <= '0;
          chan_cnt <= CHAN_W'(CHANNELS - 1);
          bit_cnt  <= BIT_W'(GRAY_BITS - 1);
        end
      end else if (bit_cnt != '0) begin
        bit_cnt <= bit_cnt - 1'b1;
      end else begin
        bit_cnt <= BIT_W'(GRAY_BITS - 1);
        if (chan_cnt != '0) begin
          chan_cnt <= chan_cnt - 1'b1;
        end else begin
          chan_cnt <= CHAN_W'(CHANNELS - 1);
          if (lane_cnt == LANE_W'(DRIVER_LANES - 1)) begin
            active    <= 1'b0;
            blank_cnt <= BLANK_W'(BLANKING_CYCLES - 1);
            frame_num <= frame_num + 1'b1;
          end else begin
            lane_cnt <= lane_cnt + 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: driver_controller.sv
module driver_controller (
  input  logic                                clock_33,
  input  logic                                nrst,
  input  logic                                fb_data,
  input  logic                                fb_sync,
  input  panel_pkg::brightness_t              brightness,
  input  logic [panel_pkg::CONF_BITS-1:0]     drv_conf,
  input  logic                                conf_load,
  input  logic                                sout,
  output logic                                sclk,
  output logic                                lat,
  output logic                                gclk,
  output logic [panel_pkg::DRIVER_LANES-1:0]  sin,
  output logic [panel_pkg::SOUT_BITS-1:0]     sout_capture,
  output logic [panel_pkg::FCOUNT_BITS-1:0]   frame_count
);
  import panel_pkg::*;

  logic [FRAME_BITS-2:0]    cap_buf;
  logic [FRAME_W-1:0]       cap_cnt;
  logic                     cap_active;
  logic                     frame_end;
  logic [FRAME_BITS-1:0]    shift_buf;
  logic [CONF_BITS-1:0]     conf_sr;
  logic                     conf_pending;
  logic [PHASE_BITS-1:0]    phase;
  logic [CNT_W-1:0]         cnt;
  logic                     half;
  brightness_t              bright_q;
  logic [DRIVER_LANES-1:0]  lane_bits;

  ////////////////////
  // Frame capture
  ////////////////////
  // Last bit of the frame is on fb_data this cycle
  assign frame_end = cap_active && !fb_sync && (cap_cnt == FRAME_W'(FRAME_BITS - 1));

  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      cap_active <= 1'b0;
      cap_cnt    <= '0;
    end else if (fb_sync) begin
      cap_active <= 1'b1;
      cap_cnt    <= FRAME_W'(1);
    end else if (cap_active) begin
      cap_cnt <= cap_cnt + 1'b1;
      if (frame_end) begin
        cap_active <= 1'b0;
      end
    end
  end

  // First arrived bit ends up in the MSB
  always_ff @(posedge clock_33) begin
    cap_buf <= {cap_buf[FRAME_BITS-3:0], fb_data};
  end

  // Shift buffer and config word advance at the end of each sclk high cycle
  always_ff @(posedge clock_33) begin
    if (frame_end) begin
      shift_buf <= {cap_buf, fb_data};
      conf_sr   <= drv_conf;
    end else begin
      if (phase == PH_DATA_SHIFT && half) begin
        shift_buf <= shift_buf << 1;
      end
      if (phase == PH_CONF_SHIFT && half) begin
        conf_sr <= conf_sr << 1;
      end
    end
    if (phase == PH_DATA_LAT) begin
      bright_q <= brightness;
    end
  end

  ////////////////////
  // Phase sequencer
  ////////////////////
  always_ff @(posedge clock_33 or negedge nrst) begin
    if (!nrst) begin
      phase        <= PH_IDLE;
      cnt          <= '0;
      half         <= 1'b0;
      conf_pending <= 1'b0;
      sout_capture <= '0;
      frame_count  <= '0;
    end else begin
      if (conf_load) begin
        conf_pending <= 1'b1;
      end
      if (frame_end) begin
        phase <= conf_pending ? PH_CONF_SHIFT : PH_DATA_SHIFT;
        cnt   <= '0;
        half  <= 1'b0;
      end else begin
        case (phase)
          PH_CONF_SHIFT: begin
            half <= ~half;
            if (half) begin
              if (cnt == CNT_W'(CONF_BITS - 1)) begin
                phase <= PH_CONF_LAT;
                cnt   <= '0;
              end else begin
                cnt <= cnt + 1'b1;
              end
            end
          end
          PH_CONF_LAT: begin
            if (cnt == CNT_W'(CONF_LAT_CYCLES - 1)) begin
              phase <= PH_DATA_SHIFT;
              cnt   <= '0;
              half  <= 1'b0;
              // A write landing now stays pending for the next frame
              if (!conf_load) begin
                conf_pending <= 1'b0;
              end
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          PH_DATA_SHIFT: begin
            half <= ~half;
            if (!half) begin
              // sclk rises on this edge
              sout_capture <= {sout_capture[SOUT_BITS-2:0], sout};
            end else if (cnt == CNT_W'(LANE_BITS - 1)) begin
              phase <= PH_DATA_LAT;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          PH_DATA_LAT: begin
            frame_count <= frame_count + 1'b1;
            cnt         <= '0;
            half        <= 1'b0;
            phase       <= (brightness == '0) ? PH_IDLE : PH_GCLK;
          end
          PH_GCLK: begin
            half <= ~half;
            if (half) begin
              if (cnt + 1'b1 == bright_q) begin
                phase <= PH_IDLE;
              end else begin
                cnt <= cnt + 1'b1;
              end
            end
          end
          default: phase <= PH_IDLE;
        endcase
      end
    end
  end

  ////////////////////
  // Driver pins
  ////////////////////
  always_comb begin
    for (int l = 0; l < DRIVER_LANES; l++) begin
      lane_bits[l] = shift_buf[FRAME_BITS-1-l*LANE_BITS];
    end
  end

  assign sclk = (phase == PH_CONF_SHIFT || phase == PH_DATA_SHIFT) && half;
  assign lat  = (phase == PH_CONF_LAT) || (phase == PH_DATA_LAT);
  assign gclk = (phase == PH_GCLK) && half;

  always_comb begin
    case (phase)
      // Same config word on every lane
      PH_CONF_SHIFT: sin = {DRIVER_LANES{conf_sr[CONF_BITS-1]}};
      PH_DATA_SHIFT: sin = lane_bits;
      default:       sin = '0;
    endcase
  end

endmodule

// File: led_panel.sv
module led_panel (
  input  logic                                clock_33,
  input  logic                                nrst,
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [panel_pkg::ADR_BITS-1:0]      wb_adr,
  input  logic [panel_pkg::WORD_BITS-1:0]     wb_dat_w,
  output logic [panel_pkg::WORD_BITS-1:0]     wb_dat_r,
  output logic                                wb_ack,
  input  logic                                sout,
  output logic                                sclk,
  output logic                                lat,
  output logic                                gclk,
  output logic [panel_pkg::DRIVER_LANES-1:0]  sin
);
  import panel_pkg::*;

  logic                    run;
  pattern_mode_t           pattern_mode;
  brightness_t             brightness;
  logic [GRAY_BITS-1:0]    fixed_gray;
  logic [CONF_BITS-1:0]    drv_conf;
  logic                    conf_load;
  logic                    fb_data;
  logic                    fb_sync;
  logic [SOUT_BITS-1:0]    sout_capture;
  logic [FCOUNT_BITS-1:0]  frame_count;

  // Control and status registers
  panel_wb_regs u_panel_wb_regs (
    .clock_33     (clock_33),
    .nrst         (nrst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .sout_capture (sout_capture),
    .frame_count  (frame_count),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .run          (run),
    .pattern_mode (pattern_mode),
    .brightness   (brightness),
    .fixed_gray   (fixed_gray),
    .drv_conf     (drv_conf),
    .conf_load    (conf_load)
  );

  // Test pattern source
  framebuffer_emulator u_framebuffer_emulator (
    .clock_33     (clock_33),
    .nrst         (nrst),
    .run          (run),
    .pattern_mode (pattern_mode),
    .fixed_gray   (fixed_gray),
    .fb_data      (fb_data),
    .fb_sync      (fb_sync)
  );

  driver_controller u_driver_controller (
    .clock_33     (clock_33),
    .nrst         (nrst),
    .fb_data      (fb_data),
    .fb_sync      (fb_sync),
    .brightness   (brightness),
    .drv_conf     (drv_conf),
    .conf_load    (conf_load),
    .sout         (sout),
    .sclk         (sclk),
    .lat          (lat),
    .gclk         (gclk),
    .sin          (sin),
    .sout_capture (sout_capture),
    .frame_count  (frame_count)
  );

endmodule

// File: tb_led_panel.sv
module tb_led_panel;
  import panel_pkg::*;

  localparam int NUM_ENTRIES   = 6;
  localparam int ACK_TIMEOUT   = 8;
  localparam int FRAME_PERIOD  = FRAME_BITS + BLANKING_CYCLES;
  localparam int QUIET_CYCLES  = FRAME_PERIOD + 40;
  localparam int DRAIN_TIMEOUT = 8 * FRAME_PERIOD;

  // One stimulus row with its expected results
  typedef struct packed {
    logic [WORD_BITS-1:0]  status_poke;
    pattern_mode_t         mode;
    brightness_t           bright;
    logic                  gray_random;
    logic [GRAY_BITS-1:0]  gray;
    logic                  conf_en;
    logic [CONF_BITS-1:0]  conf;
    logic [3:0]            frames;
    logic [SOUT_BITS-1:0]  sout_word;
  } entry_t;

  logic                     clock_33;
  logic                     nrst;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [ADR_BITS-1:0]      wb_adr;
  logic [WORD_BITS-1:0]     wb_dat_w;
  logic [WORD_BITS-1:0]     wb_dat_r;
  logic                     wb_ack;
  logic                     sout;
  logic                     sclk;
  logic                     lat;
  logic                     gclk;
  logic [DRIVER_LANES-1:0]  sin;

  entry_t                   entries [NUM_ENTRIES];
  integer                   seed;

  // Expected state, written by the main sequence only
  pattern_mode_t            exp_mode = '0;
  logic [GRAY_BITS-1:0]     exp_gray = '0;
  brightness_t              exp_bright = '0;
  logic [CONF_BITS-1:0]     exp_conf = '0;
  int                       conf_writes = 0;
  logic [SOUT_BITS-1:0]     sout_word = '0;

  // Driver chain model state
  logic [LANE_BITS-1:0]     lane_sr [DRIVER_LANES];
  int                       shift_bits = 0;
  int                       sout_idx = 0;
  int                       lat_width = 0;
  int                       gclk_cnt = 0;
  int                       gclk_low = 0;
  logic                     gclk_armed = 1'b0;
  int                       data_latches = 0;
  int                       conf_shifts = 0;
  logic                     sclk_q = 1'b0;
  logic                     gclk_q = 1'b0;

  led_panel u_led_panel (
    .clock_33 (clock_33),
    .nrst     (nrst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .sout     (sout),
    .sclk     (sclk),
    .lat      (lat),
    .gclk     (gclk),
    .sin      (sin)
  );

  initial begin
    clock_33 = 1'b0;
    forever begin
      #5 clock_33 = ~clock_33;
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input panel_word_u got, input panel_word_u exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_gray(input string name, input logic [GRAY_BITS-1:0] got,
                            input logic [GRAY_BITS-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR %s got 0x%04h expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_on_error($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Gray value for lane, channel and frame number
  function automatic logic [GRAY_BITS-1:0] expected_gray(input int lane, input int chan,
                                                         input int frame);
    logic [GRAY_BITS-1:0] value;
    case (exp_mode)
      2'd0:    value = '0;
      2'd1:    value = '1;
      2'd2:    value = GRAY_BITS'(lane * 256 + chan * 16 + (frame % 16));
      default: value = exp_gray;
    endcase
    return value;
  endfunction

  ////////////////////
  // Wishbone master
  ////////////////////
  // Called one time unit after a rising edge, returns the same way
  task automatic bus_access(input logic we, input logic [ADR_BITS-1:0] adr,
                            input logic [WORD_BITS-1:0] wdata, output panel_word_u rdata);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clock_33);
    while (!wb_ack && waited < ACK_TIMEOUT) begin
      waited++;
      @(negedge clock_33);
    end
    if (!wb_ack) begin
      stop_on_error("Wishbone access was never acknowledged");
    end
    check_count("wb_ack delay", waited, 1);
    rdata = wb_dat_r;
    @(posedge clock_33);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clock_33);
    check_count("wb_ack", int'(wb_ack), 0);
    @(posedge clock_33);
    #1;
  endtask

  task automatic write_reg(input logic [ADR_BITS-1:0] adr, input logic [WORD_BITS-1:0] data);
    panel_word_u unused_rd;
    bus_access(1'b1, adr, data, unused_rd);
  endtask

  task automatic read_reg(input logic [ADR_BITS-1:0] adr, output panel_word_u data);
    bus_access(1'b0, adr, '0, data);
  endtask

  ////////////////////
  // Driver chain model
  ////////////////////
  task automatic close_latch(input int width);
    panel_word_u got_w;
    panel_word_u exp_w;
    if (width == CONF_LAT_CYCLES) begin
      if (conf_shifts >= conf_writes) begin
        stop_on_error("configuration latch seen without a pending configuration write");
      end
      check_count("configuration bits", shift_bits, CONF_BITS);
      exp_w               = '0;
      exp_w.conf.drv_conf = exp_conf;
      for (int l = 0; l < DRIVER_LANES; l++) begin
        got_w               = '0;
        got_w.conf.drv_conf = lane_sr[l][CONF_BITS-1:0];
        check_word($sformatf("sin[%0d] configuration", l), got_w, exp_w);
      end
      conf_shifts++;
    end else begin
      check_count("lat width", width, 1);
      check_count("data bits", shift_bits, LANE_BITS);
      // Channel CHANNELS-1 arrived first and sits at the top
      for (int l = 0; l < DRIVER_LANES; l++) begin
        for (int c = 0; c < CHANNELS; c++) begin
          check_gray($sformatf("sin[%0d] channel %0d", l, c),
                     lane_sr[l][c*GRAY_BITS +: GRAY_BITS], expected_gray(l, c, data_latches));
        end
      end
      data_latches++;
      gclk_cnt   = 0;
      gclk_low   = 0;
      gclk_armed = 1'b1;
    end
    shift_bits = 0;
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clock_33) begin
    if (lat) begin
      lat_width++;
      sout_idx = 0;
    end else if (lat_width != 0) begin
      close_latch(lat_width);
      lat_width = 0;
    end
    if (sclk && !sclk_q) begin
      for (int l = 0; l < DRIVER_LANES; l++) begin
        lane_sr[l] = {lane_sr[l][LANE_BITS-2:0], sin[l]};
      end
      shift_bits++;
      sout_idx++;
    end
    if (gclk) begin
      if (gclk_q) begin
        stop_on_error("gclk stayed high for more than one cycle");
      end
      gclk_cnt++;
      gclk_low = 0;
    end else begin
      gclk_low++;
    end
    // Two low cycles in a row end the grayscale burst
    if (gclk_armed && gclk_low >= 2) begin
      check_count("gclk pulses", gclk_cnt, int'(exp_bright));
      gclk_armed = 1'b0;
    end
    sclk_q = sclk;
    gclk_q = gclk;
  end

  // Readback word leaves the chain MSB first, one bit per sclk
  initial begin
    sout = 1'b0;
    forever begin
      @(posedge clock_33);
      #1;
      sout = sout_word[SOUT_BITS-1-(sout_idx % SOUT_BITS)];
    end
  end

  ////////////////////
  // Stimulus table
  ////////////////////
  task automatic load_entries();
    entries[0] = '{status_poke: 32'hffff_ffff, mode: 2'd0, bright: 6'd5, gray_random: 1'b0,
                   gray: 16'h0000, conf_en: 1'b0, conf: 24'h0, frames: 4'd2, sout_word: 16'ha55a};
    entries[1] = '{status_poke: 32'h1234_5678, mode: 2'd1, bright: 6'd0, gray_random: 1'b0,
                   gray: 16'h0000, conf_en: 1'b1, conf: 24'hc3a501, frames: 4'd2,
                   sout_word: 16'h1234};
    entries[2] = '{status_poke: 32'h0000_beef, mode: 2'd2, bright: 6'd63, gray_random: 1'b0,
                   gray: 16'h0000, conf_en: 1'b0, conf: 24'h0, frames: 4'd3, sout_word: 16'hffff};
    entries[3] = '{status_poke: 32'h00ff_ffff, mode: 2'd3, bright: 6'd17, gray_random: 1'b1,
                   gray: 16'h0000, conf_en: 1'b1, conf: 24'h5a0f3c, frames: 4'd2,
                   sout_word: 16'h8001};
    entries[4] = '{status_poke: 32'h8000_0000, mode: 2'd3, bright: 6'd1, gray_random: 1'b1,
                   gray: 16'h0000, conf_en: 1'b0, conf: 24'h0, frames: 4'd2, sout_word: 16'h0000};
    // Enough frames to wrap the frame nibble
    entries[5] = '{status_poke: 32'h0f0f_0f0f, mode: 2'd2, bright: 6'd9, gray_random: 1'b0,
                   gray: 16'h0000, conf_en: 1'b1, conf: 24'hffffff, frames: 4'd6,
                   sout_word: 16'hbeef};
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (entries[e].gray_random) begin
        entries[e].gray = GRAY_BITS'($random(seed));
      end
    end
  endtask

  task automatic run_entry(input entry_t ent);
    panel_word_u rd;
    panel_word_u exp_w;
    panel_word_u status_before;
    int          target;
    int          waited;
    int          quiet;
    // Status is read only
    read_reg(REG_STATUS, status_before);
    write_reg(REG_STATUS, ent.status_poke);
    read_reg(REG_STATUS, rd);
    check_word("status after write", rd, status_before);

    exp_mode   = ent.mode;
    exp_bright = ent.bright;
    exp_gray   = ent.gray;
    sout_word  = ent.sout_word;
    exp_w      = WORD_BITS'(ent.gray);
    write_reg(REG_GRAY, exp_w);
    read_reg(REG_GRAY, rd);
    check_word("fixed_gray", rd, exp_w);
    if (ent.conf_en) begin
      exp_conf = ent.conf;
      conf_writes++;
      exp_w               = '0;
      exp_w.conf.drv_conf = ent.conf;
      write_reg(REG_DRV_CONF, exp_w);
      read_reg(REG_DRV_CONF, rd);
      check_word("drv_conf", rd, exp_w);
    end
    exp_w                   = '0;
    exp_w.ctrl.run          = 1'b1;
    exp_w.ctrl.pattern_mode = ent.mode;
    exp_w.ctrl.brightness   = ent.bright;
    write_reg(REG_CTRL, exp_w);
    read_reg(REG_CTRL, rd);
    check_word("ctrl", rd, exp_w);

    target = data_latches + int'(ent.frames);
    waited = 0;
    while (data_latches < target && waited < (int'(ent.frames) + 2) * FRAME_PERIOD) begin
      @(posedge clock_33);
      waited++;
    end
    if (data_latches < target) begin
      stop_on_error("timed out waiting for data latches");
    end
    #1;
    exp_w.ctrl.run = 1'b0;
    write_reg(REG_CTRL, exp_w);

    // Frames in flight finish, then the pins stay quiet
    quiet  = 0;
    waited = 0;
    while (quiet < QUIET_CYCLES && waited < DRAIN_TIMEOUT) begin
      @(negedge clock_33);
      waited++;
      if (sclk || lat || gclk) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    if (quiet < QUIET_CYCLES) begin
      stop_on_error("driver pins kept toggling after run was cleared");
    end
    @(posedge clock_33);
    #1;
    check_count("configuration shifts", conf_shifts, conf_writes);
    read_reg(REG_STATUS, rd);
    exp_w = WORD_BITS'({FCOUNT_BITS'(data_latches), ent.sout_word});
    check_word("status", rd, exp_w);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    panel_word_u rd;
    seed     = 32'h9b9c;
    nrst     = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    load_entries();
    repeat (8) @(posedge clock_33);
    #1;
    nrst = 1'b1;

    @(negedge clock_33);
    check_count("sclk", int'(sclk), 0);
    check_count("lat", int'(lat), 0);
    check_count("gclk", int'(gclk), 0);
    check_count("sin", int'(sin), 0);
    check_count("wb_ack", int'(wb_ack), 0);
    @(posedge clock_33);
    #1;
    for (int a = 0; a < 4; a++) begin
      read_reg(ADR_BITS'(a), rd);
      check_word($sformatf("wb_dat_r at address %0d", a), rd, '0);
    end

    for (int e = 0; e < NUM_ENTRIES; e++) begin
      run_entry(entries[e]);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: led_panel.f
panel_pkg.sv
panel_wb_regs.sv
framebuffer_emulator.sv
driver_controller.sv
led_panel.sv
tb_led_panel.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --timing
SIM_FLAGS = --binary -j 0
TOP       = tb_led_panel
FILELIST  = led_panel.f
OBJ_DIR   = obj_dir
PASS_TEXT = PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
